/* all.f */
hw/mips_trace_pkg.sv
hw/trace_capture.sv
hw/trace_fifo.sv
hw/inst_ascii_decoder.sv
hw/trace_printer.sv
hw/mips_trace_top.sv
bench/mips_trace_asserts.sv
bench/tb_mips_trace.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_mips_trace
FILELIST   := all.f
OBJDIR     := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJDIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* bench/tb_mips_trace.sv */
module tb_mips_trace;

    typedef struct packed {
        mips_trace_pkg::pc_t       pc;
        mips_trace_pkg::instr_t    instr;
        mips_trace_pkg::mnemonic_t mnem;
    } row_t;

    localparam int NUM_ROWS        = 35;
    localparam int HOLD_BURST      = mips_trace_pkg::FIFO_DEPTH + 4;
    // FIFO entries plus the capture register
    localparam int ACCEPTED        = mips_trace_pkg::FIFO_DEPTH + 1;
    // Full FIFO and capture register draining, plus two cycles of latency
    localparam int DRAIN_CYCLES    = 2 * (ACCEPTED + 2);
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 40) * 20;

    logic                        clk;
    logic                        rst_n;
    logic                        commit_valid;
    mips_trace_pkg::pc_t         commit_pc;
    mips_trace_pkg::instr_t      commit_instr;
    logic                        hold;
    logic                        line_valid;
    mips_trace_pkg::trace_line_t line;
    mips_trace_pkg::drop_count_t drop_count;

    mips_trace_pkg::trace_line_t expected_q [$];
    mips_trace_pkg::seq_t        next_seq;
    integer                      seed;

    ////////////////////////////////////////
    // Stimulus table: pc, instr, mnemonic
    ////////////////////////////////////////

    row_t rows [NUM_ROWS] = '{
        '{32'h0040_0000, 32'h0085_1824, "AND     "},
        '{32'h0040_0004, 32'h00a4_1004, "SLLV    "},
        '{32'h0040_0008, 32'h0085_0019, "MULTU   "},
        '{32'h0040_000c, 32'h0080_f809, "JALR    "},
        '{32'h0040_0010, 32'h0000_000c, "SYSCALL "},
        '{32'h0040_0014, 32'h0085_0033, "TLTU    "},
        '{32'h0040_0018, 32'h0085_180b, "MOVN    "},
        // I-type, jumps, branch likely
        '{32'h0040_001c, 32'h3084_00ff, "ANDI    "},
        '{32'h0040_0020, 32'h2484_0001, "ADDIU   "},
        '{32'h0040_0024, 32'h3c01_1234, "LUI     "},
        '{32'h0040_0028, 32'h0800_0040, "J       "},
        '{32'h0040_002c, 32'h0c00_0040, "JAL     "},
        '{32'h0040_0030, 32'h5085_0004, "BEQL    "},
        '{32'h0040_0034, 32'h5c80_0004, "BGTZL   "},
        // Loads and stores
        '{32'h0040_0038, 32'h8c82_0000, "LW      "},
        '{32'h0040_003c, 32'ha082_0003, "SB      "},
        '{32'h0040_0040, 32'h8882_0000, "LWL     "},
        '{32'h0040_0044, 32'he082_0000, "SC      "},
        // REGIMM
        '{32'h0040_0048, 32'h0493_0004, "BGEZALL "},
        '{32'h0040_004c, 32'h0488_0010, "TGEI    "},
        '{32'h0040_0050, 32'h0489_0010, "TGEIU   "},
        '{32'h0040_0054, 32'h0480_0004, "BLTZ    "},
        // COP0
        '{32'h0040_0058, 32'h4200_0018, "ERET    "},
        '{32'h0040_005c, 32'h4002_6000, "MFC0    "},
        '{32'h0040_0060, 32'h4082_6000, "MTC0    "},
        '{32'h0040_0064, 32'h4200_0020, "WAIT    "},
        // SPECIAL2, CACHE and PREF
        '{32'h0040_0068, 32'h7085_1802, "MUL     "},
        '{32'h0040_006c, 32'h7080_1020, "CLZ     "},
        '{32'h0040_0070, 32'h7085_0001, "MADDU   "},
        '{32'h0040_0074, 32'hbc80_0000, "CACHE   "},
        '{32'h0040_0078, 32'hcc80_0000, "PREF    "},
        // NOP and undefined encodings
        '{32'h0040_007c, 32'h0000_0000, mips_trace_pkg::MNEM_NOP},
        '{32'h0040_0080, 32'hfc00_0000, mips_trace_pkg::MNEM_UNKNOWN},
        '{32'h0040_0084, 32'h0000_0001, mips_trace_pkg::MNEM_UNKNOWN},
        '{32'h0040_0088, 32'h041f_0000, mips_trace_pkg::MNEM_UNKNOWN}
    };

    mips_trace_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_instr (commit_instr),
        .hold         (hold),
        .line_valid   (line_valid),
        .line         (line),
        .drop_count   (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_line(input mips_trace_pkg::trace_line_t got,
                              input mips_trace_pkg::trace_line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: line seq %0d pc %h \"%s\", expected seq %0d pc %h \"%s\"",
                               $time, got.seq, got.pc, got.mnemonic,
                               exp.seq, exp.pc, exp.mnemonic));
        end
    endtask

    task automatic check_drops(input mips_trace_pkg::drop_count_t got,
                               input mips_trace_pkg::drop_count_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: drop_count %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t: line_valid %b, expected %b", $time, got, exp));
        end
    endtask

    // Every trace line must match the oldest accepted commit
    always @(negedge clk) begin
        if (rst_n && line_valid) begin
            if (expected_q.size() == 0) begin
                stop_run($sformatf("Trace line with seq %0d arrived when none was expected",
                                   line.seq));
            end else begin
                check_line(line, expected_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_run($sformatf("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////

    task automatic send(input row_t r, input logic accepted);
        mips_trace_pkg::trace_line_t exp_line;
        @(posedge clk);
        #1;
        commit_valid = 1'b1;
        commit_pc    = r.pc;
        commit_instr = r.instr;
        if (accepted) begin
            exp_line.seq      = next_seq;
            exp_line.pc       = r.pc;
            exp_line.mnemonic = r.mnem;
            expected_q.push_back(exp_line);
        end
        next_seq = next_seq + 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            commit_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (expected_q.size() != 0) begin
            stop_run("Expected trace lines did not arrive after the FIFO should have drained");
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        commit_valid = 1'b0;
        commit_pc    = '0;
        commit_instr = '0;
        hold         = 1'b0;
        next_seq     = '0;
        seed         = 32'hb7bc;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_strobe(line_valid, 1'b0);
        check_drops(drop_count, '0);

        // Whole table back to back
        for (int i = 0; i < NUM_ROWS; i++) begin
            send(rows[i], 1'b1);
        end
        idle(1);
        wait_drain();
        check_drops(drop_count, '0);

        // Burst under hold, the last few overflow
        @(posedge clk);
        #1;
        hold = 1'b1;
        for (int i = 0; i < HOLD_BURST; i++) begin
            send(rows[i], i < ACCEPTED);
        end
        idle(4);
        @(negedge clk);
        check_drops(drop_count, 16'(HOLD_BURST - ACCEPTED));
        idle(1);
        hold = 1'b0;
        wait_drain();

        // Random hold, one commit every third cycle
        for (int i = 0; i < NUM_ROWS; i++) begin
            send(rows[i], 1'b1);
            hold = 1'b0;
            repeat (2) begin
                @(posedge clk);
                #1;
                commit_valid = 1'b0;
                hold         = 1'($random(seed));
            end
        end
        idle(1);
        hold = 1'b0;
        wait_drain();
        idle(2);
        @(negedge clk);
        check_drops(drop_count, 16'(HOLD_BURST - ACCEPTED));

        $display("All tests passed");
        $finish;
    end

endmodule

/* bench/mips_trace_asserts.sv */
module mips_trace_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        push,
    input logic                        pop,
    input logic                        full,
    input logic                        empty,
    input logic                        line_valid,
    input mips_trace_pkg::trace_line_t line,
    input mips_trace_pkg::drop_count_t drop_count
);

    ////////////////////////////////////////
    // FIFO rules
    ////////////////////////////////////////

    // A write into an empty FIFO reaches the head one edge later
    push_clears_empty: assert property (@(posedge clk) disable iff (!rst_n)
        push && empty |=> !empty)
        else $error("FIFO still empty after a write");

    pop_clears_full: assert property (@(posedge clk) disable iff (!rst_n)
        pop && full |=> !full)
        else $error("FIFO still full after a read");

    // Back-to-back strobes carry distinct lines
    one_strobe_per_line: assert property (@(posedge clk) disable iff (!rst_n)
        line_valid && $past(line_valid) |-> line != $past(line))
        else $error("line_valid held over the same trace line");

    drops_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        drop_count >= $past(drop_count))
        else $error("drop_count decreased");

endmodule

bind mips_trace_top mips_trace_asserts asserts_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .pop        (pop),
    .full       (full),
    .empty      (empty),
    .line_valid (line_valid),
    .line       (line),
    .drop_count (drop_count)
);

/* hw/mips_trace_top.sv */
module mips_trace_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         commit_valid,
    input  mips_trace_pkg::pc_t          commit_pc,
    input  mips_trace_pkg::instr_t       commit_instr,
    input  logic                         hold,
    output logic                         line_valid,
    output mips_trace_pkg::trace_line_t  line,
    output mips_trace_pkg::drop_count_t  drop_count
);

    logic                          push;
    logic                          pop;
    logic                          full;
    logic                          empty;
    mips_trace_pkg::trace_entry_t  push_entry;
    mips_trace_pkg::trace_entry_t  head;

    // Producer
    trace_capture capture_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_instr (commit_instr),
        .full         (full),
        .push         (push),
        .push_entry   (push_entry),
        .drop_count   (drop_count)
    );

    trace_fifo #(
        .depth (mips_trace_pkg::FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (full)
    );

    // Consumer
    trace_printer printer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .head       (head),
        .hold       (hold),
        .pop        (pop),
        .line_valid (line_valid),
        .line       (line)
    );

endmodule

/* hw/trace_printer.sv */
module trace_printer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          empty,
    input  mips_trace_pkg::trace_entry_t  head,
    input  logic                          hold,
    output logic                          pop,
    output logic                          line_valid,
    output mips_trace_pkg::trace_line_t   line
);

    mips_trace_pkg::mnemonic_t mnemonic;

    // Drain one entry per cycle unless held off
    assign pop = !empty && !hold;

    inst_ascii_decoder decoder_i (
        .instr    (head.instr),
        .mnemonic (mnemonic)
    );

    ////////////////////////////////////////
    // Trace line register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            line <= '{seq: head.seq, pc: head.pc, mnemonic: mnemonic};
        end
    end

endmodule

/* hw/inst_ascii_decoder.sv */
module inst_ascii_decoder (
    input  mips_trace_pkg::instr_t     instr,
    output mips_trace_pkg::mnemonic_t  mnemonic
);

    always_comb begin
        case (instr[31:26])
            mips_trace_pkg::OP_SPECIAL: begin
                case (instr[5:0])
                    // Logic
                    mips_trace_pkg::FN_AND:     mnemonic = "AND     ";
                    mips_trace_pkg::FN_OR:      mnemonic = "OR      ";
                    mips_trace_pkg::FN_XOR:     mnemonic = "XOR     ";
                    mips_trace_pkg::FN_NOR:     mnemonic = "NOR     ";
                    // Shifts
                    mips_trace_pkg::FN_SLL:     mnemonic = "SLL     ";
                    mips_trace_pkg::FN_SRL:     mnemonic = "SRL     ";
                    mips_trace_pkg::FN_SRA:     mnemonic = "SRA     ";
                    mips_trace_pkg::FN_SLLV:    mnemonic = "SLLV    ";
                    mips_trace_pkg::FN_SRLV:    mnemonic = "SRLV    ";
                    mips_trace_pkg::FN_SRAV:    mnemonic = "SRAV    ";
                    // HI/LO moves
                    mips_trace_pkg::FN_MFHI:    mnemonic = "MFHI    ";
                    mips_trace_pkg::FN_MTHI:    mnemonic = "MTHI    ";
                    mips_trace_pkg::FN_MFLO:    mnemonic = "MFLO    ";
                    mips_trace_pkg::FN_MTLO:    mnemonic = "MTLO    ";
                    // Arithmetic
                    mips_trace_pkg::FN_ADD:     mnemonic = "ADD     ";
                    mips_trace_pkg::FN_ADDU:    mnemonic = "ADDU    ";
                    mips_trace_pkg::FN_SUB:     mnemonic = "SUB     ";
                    mips_trace_pkg::FN_SUBU:    mnemonic = "SUBU    ";
                    mips_trace_pkg::FN_SLT:     mnemonic = "SLT     ";
                    mips_trace_pkg::FN_SLTU:    mnemonic = "SLTU    ";
                    mips_trace_pkg::FN_MULT:    mnemonic = "MULT    ";
                    mips_trace_pkg::FN_MULTU:   mnemonic = "MULTU   ";
                    mips_trace_pkg::FN_DIV:     mnemonic = "DIV     ";
                    mips_trace_pkg::FN_DIVU:    mnemonic = "DIVU    ";
                    // Jumps and system
                    mips_trace_pkg::FN_JR:      mnemonic = "JR      ";
                    mips_trace_pkg::FN_JALR:    mnemonic = "JALR    ";
                    mips_trace_pkg::FN_SYSCALL: mnemonic = "SYSCALL ";
                    mips_trace_pkg::FN_BREAK:   mnemonic = "BREAK   ";
                    mips_trace_pkg::FN_SYNC:    mnemonic = "SYNC    ";
                    // Traps
                    mips_trace_pkg::FN_TEQ:     mnemonic = "TEQ     ";
                    mips_trace_pkg::FN_TNE:     mnemonic = "TNE     ";
                    mips_trace_pkg::FN_TGE:     mnemonic = "TGE     ";
                    mips_trace_pkg::FN_TGEU:    mnemonic = "TGEU    ";
                    mips_trace_pkg::FN_TLT:     mnemonic = "TLT     ";
                    mips_trace_pkg::FN_TLTU:    mnemonic = "TLTU    ";
                    // Conditional moves
                    mips_trace_pkg::FN_MOVZ:    mnemonic = "MOVZ    ";
                    mips_trace_pkg::FN_MOVN:    mnemonic = "MOVN    ";
                    default:                    mnemonic = mips_trace_pkg::MNEM_UNKNOWN;
                endcase
            end

            ////////////////////////////////////////
            // I-type and J
            ////////////////////////////////////////

            mips_trace_pkg::OP_ANDI:  mnemonic = "ANDI    ";
            mips_trace_pkg::OP_ORI:   mnemonic = "ORI     ";
            mips_trace_pkg::OP_XORI:  mnemonic = "XORI    ";
            mips_trace_pkg::OP_LUI:   mnemonic = "LUI     ";
            mips_trace_pkg::OP_ADDI:  mnemonic = "ADDI    ";
            mips_trace_pkg::OP_ADDIU: mnemonic = "ADDIU   ";
            mips_trace_pkg::OP_SLTI:  mnemonic = "SLTI    ";
            mips_trace_pkg::OP_SLTIU: mnemonic = "SLTIU   ";
            mips_trace_pkg::OP_J:     mnemonic = "J       ";
            mips_trace_pkg::OP_JAL:   mnemonic = "JAL     ";
            mips_trace_pkg::OP_BEQ:   mnemonic = "BEQ     ";
            mips_trace_pkg::OP_BNE:   mnemonic = "BNE     ";
            mips_trace_pkg::OP_BLEZ:  mnemonic = "BLEZ    ";
            mips_trace_pkg::OP_BGTZ:  mnemonic = "BGTZ    ";
            // Branch likely
            mips_trace_pkg::OP_BEQL:  mnemonic = "BEQL    ";
            mips_trace_pkg::OP_BNEL:  mnemonic = "BNEL    ";
            mips_trace_pkg::OP_BLEZL: mnemonic = "BLEZL   ";
            mips_trace_pkg::OP_BGTZL: mnemonic = "BGTZL   ";
            // Loads and stores
            mips_trace_pkg::OP_LB:    mnemonic = "LB      ";
            mips_trace_pkg::OP_LBU:   mnemonic = "LBU     ";
            mips_trace_pkg::OP_LH:    mnemonic = "LH      ";
            mips_trace_pkg::OP_LHU:   mnemonic = "LHU     ";
            mips_trace_pkg::OP_LW:    mnemonic = "LW      ";
            mips_trace_pkg::OP_LWL:   mnemonic = "LWL     ";
            mips_trace_pkg::OP_LWR:   mnemonic = "LWR     ";
            mips_trace_pkg::OP_SB:    mnemonic = "SB      ";
            mips_trace_pkg::OP_SH:    mnemonic = "SH      ";
            mips_trace_pkg::OP_SW:    mnemonic = "SW      ";
            mips_trace_pkg::OP_SWL:   mnemonic = "SWL     ";
            mips_trace_pkg::OP_SWR:   mnemonic = "SWR     ";
            mips_trace_pkg::OP_LL:    mnemonic = "LL      ";
            mips_trace_pkg::OP_SC:    mnemonic = "SC      ";
            mips_trace_pkg::OP_CACHE: mnemonic = "CACHE   ";
            mips_trace_pkg::OP_PREF:  mnemonic = "PREF    ";

            mips_trace_pkg::OP_REGIMM: begin
                case (instr[20:16])
                    mips_trace_pkg::RT_BGEZ:    mnemonic = "BGEZ    ";
                    mips_trace_pkg::RT_BGEZAL:  mnemonic = "BGEZAL  ";
                    mips_trace_pkg::RT_BLTZ:    mnemonic = "BLTZ    ";
                    mips_trace_pkg::RT_BLTZAL:  mnemonic = "BLTZAL  ";
                    mips_trace_pkg::RT_TEQI:    mnemonic = "TEQI    ";
                    mips_trace_pkg::RT_TNEI:    mnemonic = "TNEI    ";
                    mips_trace_pkg::RT_TGEI:    mnemonic = "TGEI    ";
                    mips_trace_pkg::RT_TGEIU:   mnemonic = "TGEIU   ";
                    mips_trace_pkg::RT_TLTI:    mnemonic = "TLTI    ";
                    mips_trace_pkg::RT_TLTIU:   mnemonic = "TLTIU   ";
                    mips_trace_pkg::RT_BGEZALL: mnemonic = "BGEZALL ";
                    mips_trace_pkg::RT_BLTZALL: mnemonic = "BLTZALL ";
                    mips_trace_pkg::RT_BGEZL:   mnemonic = "BGEZL   ";
                    mips_trace_pkg::RT_BLTZL:   mnemonic = "BLTZL   ";
                    default:                    mnemonic = mips_trace_pkg::MNEM_UNKNOWN;
                endcase
            end

            mips_trace_pkg::OP_COP0: begin
                case (instr[5:0])
                    mips_trace_pkg::FN_ERET:  mnemonic = "ERET    ";
                    mips_trace_pkg::FN_TLBP:  mnemonic = "TLBP    ";
                    mips_trace_pkg::FN_TLBR:  mnemonic = "TLBR    ";
                    mips_trace_pkg::FN_TLBWI: mnemonic = "TLBWI   ";
                    mips_trace_pkg::FN_WAIT:  mnemonic = "WAIT    ";
                    // Register moves are told apart by rs
                    default: begin
                        case (instr[25:21])
                            mips_trace_pkg::RS_MTC0: mnemonic = "MTC0    ";
                            mips_trace_pkg::RS_MFC0: mnemonic = "MFC0    ";
                            default:                 mnemonic = mips_trace_pkg::MNEM_UNKNOWN;
                        endcase
                    end
                endcase
            end

            mips_trace_pkg::OP_SPECIAL2: begin
                case (instr[5:0])
                    mips_trace_pkg::FN_CLO:   mnemonic = "CLO     ";
                    mips_trace_pkg::FN_CLZ:   mnemonic = "CLZ     ";
                    mips_trace_pkg::FN_MADD:  mnemonic = "MADD    ";
                    mips_trace_pkg::FN_MADDU: mnemonic = "MADDU   ";
                    mips_trace_pkg::FN_MSUB:  mnemonic = "MSUB    ";
                    mips_trace_pkg::FN_MSUBU: mnemonic = "MSUBU   ";
                    mips_trace_pkg::FN_MUL:   mnemonic = "MUL     ";
                    default:                  mnemonic = mips_trace_pkg::MNEM_UNKNOWN;
                endcase
            end

            default: mnemonic = mips_trace_pkg::MNEM_UNKNOWN;
        endcase

        // All-zero is sll $0,$0,0
        if (instr == '0) begin
            mnemonic = mips_trace_pkg::MNEM_NOP;
        end
    end

endmodule

/* hw/trace_fifo.sv */
module trace_fifo #(
    parameter int depth = mips_trace_pkg::FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  mips_trace_pkg::trace_entry_t  push_entry,
    input  logic                          pop,
    output mips_trace_pkg::trace_entry_t  head,
    output logic                          empty,
    output logic                          full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    mips_trace_pkg::trace_entry_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // Show-ahead read
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/trace_capture.sv */
module trace_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          commit_valid,
    input  mips_trace_pkg::pc_t           commit_pc,
    input  mips_trace_pkg::instr_t        commit_instr,
    input  logic                          full,
    output logic                          push,
    output mips_trace_pkg::trace_entry_t  push_entry,
    output mips_trace_pkg::drop_count_t   drop_count
);

    mips_trace_pkg::seq_t seq;
    logic                 held;
    logic                 take;

    // Register is free if empty or draining into the FIFO this cycle
    assign take = commit_valid && (!held || !full);
    assign push = held && !full;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq        <= '0;
            held       <= 1'b0;
            drop_count <= '0;
        end else begin
            // Every commit takes a number, so drops leave a gap
            if (commit_valid) begin
                seq <= seq + 1'b1;
            end
            if (take) begin
                held <= 1'b1;
            end else if (push) begin
                held <= 1'b0;
            end
            // Saturating drop count
            if (commit_valid && !take && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (take) begin
            push_entry <= '{seq: seq, pc: commit_pc, instr: commit_instr};
        end
    end

endmodule

/* hw/mips_trace_pkg.sv */
package mips_trace_pkg;

    ////////////////////////////////////////
    // Trace types
    ////////////////////////////////////////

    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;
    // Wraps, and counts dropped commits too
    typedef logic [7:0]  seq_t;
    // Eight ASCII chars, first one in the top byte, space padded
    typedef logic [63:0] mnemonic_t;
    typedef logic [15:0] drop_count_t;

    typedef struct packed {
        seq_t   seq;
        pc_t    pc;
        instr_t instr;
    } trace_entry_t;

    typedef struct packed {
        seq_t      seq;
        pc_t       pc;
        mnemonic_t mnemonic;
    } trace_line_t;

    localparam int FIFO_DEPTH = 8;

    localparam mnemonic_t MNEM_NOP     = "NOP     ";
    localparam mnemonic_t MNEM_UNKNOWN = "N-R     ";

    ////////////////////////////////////////
    // MIPS32 encodings
    ////////////////////////////////////////

    // Major opcode, instr[31:26]
    localparam logic [5:0]
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL      = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ     = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU    = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI      = 6'h0f,
        OP_COP0    = 6'h10, OP_BEQL   = 6'h14, OP_BNEL  = 6'h15, OP_BLEZL    = 6'h16,
        OP_BGTZL   = 6'h17, OP_SPECIAL2 = 6'h1c,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LWL   = 6'h22, OP_LW       = 6'h23,
        OP_LBU     = 6'h24, OP_LHU    = 6'h25, OP_LWR   = 6'h26, OP_SB       = 6'h28,
        OP_SH      = 6'h29, OP_SWL    = 6'h2a, OP_SW    = 6'h2b, OP_SWR      = 6'h2e,
        OP_CACHE   = 6'h2f, OP_LL     = 6'h30, OP_PREF  = 6'h33, OP_SC       = 6'h38;

    // SPECIAL funct, instr[5:0]
    localparam logic [5:0]
        FN_SLL   = 6'h00, FN_SRL   = 6'h02, FN_SRA  = 6'h03, FN_SLLV    = 6'h04,
        FN_SRLV  = 6'h06, FN_SRAV  = 6'h07, FN_JR   = 6'h08, FN_JALR    = 6'h09,
        FN_MOVZ  = 6'h0a, FN_MOVN  = 6'h0b, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
        FN_SYNC  = 6'h0f, FN_MFHI  = 6'h10, FN_MTHI = 6'h11, FN_MFLO    = 6'h12,
        FN_MTLO  = 6'h13, FN_MULT  = 6'h18, FN_MULTU = 6'h19, FN_DIV    = 6'h1a,
        FN_DIVU  = 6'h1b, FN_ADD   = 6'h20, FN_ADDU = 6'h21, FN_SUB     = 6'h22,
        FN_SUBU  = 6'h23, FN_AND   = 6'h24, FN_OR   = 6'h25, FN_XOR     = 6'h26,
        FN_NOR   = 6'h27, FN_SLT   = 6'h2a, FN_SLTU = 6'h2b, FN_TGE     = 6'h30,
        FN_TGEU  = 6'h31, FN_TLT   = 6'h32, FN_TLTU = 6'h33, FN_TEQ     = 6'h34,
        FN_TNE   = 6'h36;

    // REGIMM rt, instr[20:16]
    localparam logic [4:0]
        RT_BLTZ   = 5'h00, RT_BGEZ   = 5'h01, RT_BLTZL   = 5'h02, RT_BGEZL   = 5'h03,
        RT_TGEI   = 5'h08, RT_TGEIU  = 5'h09, RT_TLTI    = 5'h0a, RT_TLTIU   = 5'h0b,
        RT_TEQI   = 5'h0c, RT_TNEI   = 5'h0e, RT_BLTZAL  = 5'h10, RT_BGEZAL  = 5'h11,
        RT_BLTZALL = 5'h12, RT_BGEZALL = 5'h13;

    // COP0 rs, instr[25:21]
    localparam logic [4:0] RS_MFC0 = 5'h00, RS_MTC0 = 5'h04;

    // COP0 funct
    localparam logic [5:0]
        FN_TLBR = 6'h01, FN_TLBWI = 6'h02, FN_TLBP = 6'h08, FN_ERET = 6'h18,
        FN_WAIT = 6'h20;

    // SPECIAL2 funct
    localparam logic [5:0]
        FN_MADD = 6'h00, FN_MADDU = 6'h01, FN_MUL = 6'h02, FN_MSUB = 6'h04,
        FN_MSUBU = 6'h05, FN_CLZ = 6'h20, FN_CLO = 6'h21;

endpackage
